//--- verification/math_mac_tests.txt
// valid_mode_op_a_b_product_acc in hex, valid 0 is an idle cycle
// op 0 load, 1 add, 2 sub, 3 spare code; valid f ends the table
1_0_1_ff_ff_fe01_00fe01
1_0_1_00_5a_0000_00fe01
1_0_1_01_80_0080_00fe81
1_0_1_80_02_0100_00ff81
1_0_2_10_10_0100_00fe81
1_0_0_0c_0d_009c_00009c
0_0_0_00_00_0000_000000
0_0_0_00_00_0000_000000
1_0_1_03_04_000c_0000a8
// signed operands, every sign pairing
1_1_0_05_fd_fff1_fffff1
1_1_1_f9_06_ffd6_ffffc7
1_1_1_f6_f8_0050_000017
1_1_2_7f_7f_3f01_ffc116
1_1_1_80_80_4000_000116
1_1_1_80_ff_0080_000196
1_1_1_ff_80_0080_000216
1_1_2_80_7f_c080_004196
1_1_1_ff_ff_0001_004197
1_1_1_00_80_0000_004197
// mode changes between operations
1_0_1_80_80_4000_008197
1_1_1_80_01_ff80_008117
0_0_0_00_00_0000_000000
// wrap past the top, then below zero
1_1_0_80_7f_c080_ffc080
1_0_1_ff_ff_fe01_00be81
1_0_0_02_03_0006_000006
1_0_2_ff_02_01fe_fffe08
1_1_2_fe_02_fffc_fffe0c
1_0_3_07_07_0031_000031
1_0_1_01_01_0001_000032
1_0_1_ff_00_0000_000032
1_0_1_40_02_0080_0000b2
1_1_1_7f_80_c080_ffc132
1_0_1_ff_01_00ff_ffc231
1_0_1_c8_64_4e20_001051
1_1_0_c8_64_ea20_ffea20
0_0_0_00_00_0000_000000
f_0_0_00_00_0000_000000

//--- vlog.f
rtl/math_cfg_pkg.sv
rtl/math_op_pkg.sv
rtl/math_multiplier_basic_cell.sv
rtl/math_multiplier_carry_save.sv
rtl/math_signed_multiply_stage.sv
rtl/math_mac_unit.sv
verification/math_mac_unit_tb.sv

//--- run_verilator.sh
#!/bin/sh
# build and run the MAC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal -j 0 \
    --top-module math_mac_unit_tb \
    -f vlog.f \
    -o math_mac_sim

# the simulation exits non-zero on failure, keep its output for the search
sim_out=$(./obj_dir/math_mac_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx '=== PASS ==='; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- verification/math_mac_unit_tb.sv
`timescale 1ns/10ps

module math_mac_unit_tb
    import math_cfg_pkg::*;
    import math_op_pkg::*;
();
    localparam int N            = MATH_OPERAND_W;
    localparam int ACC_W        = MATH_ACC_W;
    localparam int PROD_W       = 2*N;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_VEC      = 256;
    localparam int ACC_LATENCY  = 2;  // sampling edge to acc_valid

    // one table line, nibble aligned fields from the lsb upwards
    localparam int B_LSB     = ACC_W + PROD_W;
    localparam int A_LSB     = B_LSB + N;
    localparam int OP_LSB    = A_LSB + N;
    localparam int MODE_LSB  = OP_LSB + 4;
    localparam int VALID_LSB = MODE_LSB + 4;
    localparam int VEC_W     = VALID_LSB + 4;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic [N-1:0]      a;
    logic [N-1:0]      b;
    logic              signed_mode;
    mac_op_e           op;
    logic [PROD_W-1:0] product;
    logic              product_valid;
    logic [ACC_W-1:0]  acc;
    logic              acc_valid;

    logic [VEC_W-1:0]  vec_mem [0:MAX_VEC-1];
    int                num_vec;
    bit                loaded;

    // expected results, oldest operation at the front
    logic [PROD_W-1:0] prod_q [$];
    logic [ACC_W-1:0]  acc_q  [$];

    math_mac_unit #(
        .N     (N),
        .ACC_W (ACC_W)
    ) u_math_mac_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .a             (a),
        .b             (b),
        .signed_mode   (signed_mode),
        .op            (op),
        .product       (product),
        .product_valid (product_valid),
        .acc           (acc),
        .acc_valid     (acc_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_product(input logic [PROD_W-1:0] got, input logic [PROD_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: product is 0x%h, expected 0x%h", got, exp));
        end
    endtask

    task automatic check_acc(input logic [ACC_W-1:0] got, input logic [ACC_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: acc is 0x%h, expected 0x%h", got, exp));
        end
    endtask

    task automatic load_vectors();
        bit found;
        found = 1'b0;
        $readmemh("verification/math_mac_tests.txt", vec_mem);
        for (int i = 0; i < MAX_VEC && !found; i++) begin
            if (vec_mem[i][VALID_LSB +: 4] == 4'hf) begin  // end marker
                num_vec = i;
                found   = 1'b1;
            end
        end
        if (!found) begin
            fail_run("the test table has no end marker line");
        end else begin
            loaded = 1'b1;
        end
    endtask

    task automatic drive_vector(input logic [VEC_W-1:0] vec);
        logic vld;
        vld = vec[VALID_LSB];
        in_valid    <= vld;
        signed_mode <= vec[MODE_LSB];
        op          <= mac_op_e'(vec[OP_LSB +: 2]);
        a           <= vec[A_LSB +: N];
        b           <= vec[B_LSB +: N];
        if (vld) begin
            prod_q.push_back(vec[ACC_W +: PROD_W]);
            acc_q.push_back(vec[ACC_W-1:0]);
        end
    endtask

    // outputs are sampled mid cycle, away from the driving edge
    always @(negedge clk) begin
        if (product_valid) begin
            if (prod_q.size() == 0) begin
                fail_run("product_valid was high with no operation outstanding");
            end else begin
                check_product(product, prod_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (acc_valid) begin
            if (acc_q.size() == 0) begin
                fail_run("acc_valid was high with no operation outstanding");
            end else begin
                check_acc(acc, acc_q.pop_front());
            end
        end
    end

    // watchdog, counted from the end of reset
    initial begin
        wait (loaded && rst_n === 1'b1);
        #((num_vec + 20) * CLK_PERIOD);
        fail_run("timeout: the DUT did not return all results in time");
    end

    initial begin
        in_valid    = 1'b0;
        a           = '0;
        b           = '0;
        signed_mode = 1'b0;
        op          = OP_LOAD;
        rst_n       = 1'b0;
        load_vectors();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_product(product, '0);  // registers come out of reset cleared
        check_acc(acc, '0);

        for (int i = 0; i < num_vec; i++) begin
            @(posedge clk);
            drive_vector(vec_mem[i]);
        end
        @(posedge clk);
        in_valid <= 1'b0;

        // last acc is due ACC_LATENCY + 1 edges after the last drive
        // the extra cycles leave room for any stray pulse
        repeat (ACC_LATENCY + 4) @(negedge clk);

        if (prod_q.size() != 0 || acc_q.size() != 0) begin
            fail_run("results were still outstanding at the end of the run");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule : math_mac_unit_tb

//--- rtl/math_mac_unit.sv
`timescale 1ns/10ps

module math_mac_unit
    import math_cfg_pkg::*;
    import math_op_pkg::*;
#(
    parameter int N     = MATH_OPERAND_W,
    parameter int ACC_W = MATH_ACC_W      // at least 2*N
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic [N-1:0]     a,
    input  logic [N-1:0]     b,
    input  logic             signed_mode,
    input  mac_op_e          op,
    output logic [2*N-1:0]   product,
    output logic             product_valid,
    output logic [ACC_W-1:0] acc,
    output logic             acc_valid
);
    // op and mode follow the operation down the pipe
    // s1 sits beside the operand register, s2 beside the product register
    mac_op_e          op_s1;
    mac_op_e          op_s2;
    logic             mode_s1;
    logic             mode_s2;

    logic [ACC_W-1:0] prod_ext;  // product widened to the accumulator
    logic [ACC_W-1:0] acc_next;

    math_signed_multiply_stage #(
        .N (N)
    ) u_mult (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .a             (a),
        .b             (b),
        .signed_mode   (signed_mode),
        .product       (product),
        .product_valid (product_valid)
    );

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_s1   <= op;
            mode_s1 <= signed_mode;
        end
        // s2 only matters in the cycle product_valid is high
        op_s2   <= op_s1;
        mode_s2 <= mode_s1;
    end

    // sign extend signed products, zero extend unsigned ones
    assign prod_ext = mode_s2 ? ACC_W'($signed(product)) : ACC_W'(product);

    always_comb begin
        case (op_s2)
            OP_ADD:  acc_next = acc + prod_ext;  // wraps at 2**ACC_W
            OP_SUB:  acc_next = acc - prod_ext;
            default: acc_next = prod_ext;        // OP_LOAD and spare code
        endcase
    end

    // accumulator register, untouched on idle cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= product_valid;
            if (product_valid) begin
                acc <= acc_next;
            end
        end
    end

endmodule : math_mac_unit

//--- rtl/math_signed_multiply_stage.sv
`timescale 1ns/10ps

module math_signed_multiply_stage
    import math_cfg_pkg::*;
#(
    parameter int N = MATH_OPERAND_W
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  logic [N-1:0]   a,
    input  logic [N-1:0]   b,
    input  logic           signed_mode,  // 1: both operands two's complement
    output logic [2*N-1:0] product,
    output logic           product_valid
);
    // operand register
    logic [N-1:0]   a_q;
    logic [N-1:0]   b_q;
    logic           signed_q;
    logic           valid_q;

    // magnitude path
    logic           a_neg;
    logic           b_neg;
    logic           flip;         // exactly one operand negative
    logic [N-1:0]   a_mag;
    logic [N-1:0]   b_mag;
    logic [2*N-1:0] mag_product;
    logic [2*N-1:0] signed_product;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // operands only move when a new operation arrives
    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_q      <= a;
            b_q      <= b;
            signed_q <= signed_mode;
        end
    end

    // sign bits only count in signed mode
    assign a_neg = signed_q & a_q[N-1];
    assign b_neg = signed_q & b_q[N-1];

    // the most negative value maps to 2**(N-1), which still fits in N bits
    assign a_mag = a_neg ? (~a_q + 1'b1) : a_q;
    assign b_mag = b_neg ? (~b_q + 1'b1) : b_q;

    math_multiplier_carry_save #(
        .N (N)
    ) u_array (
        .multiplier   (a_mag),
        .multiplicand (b_mag),
        .product      (mag_product)
    );

    assign flip = a_neg ^ b_neg;

    // largest magnitude is 2**(2N-2), so the negated value never overflows
    assign signed_product = flip ? (~mag_product + 1'b1) : mag_product;

    // product register, holds its value between operations
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product       <= '0;
            product_valid <= 1'b0;
        end else begin
            product_valid <= valid_q;
            if (valid_q) begin
                product <= signed_product;
            end
        end
    end

endmodule : math_signed_multiply_stage

//--- rtl/math_multiplier_carry_save.sv
`timescale 1ns/10ps

module math_multiplier_carry_save
    import math_cfg_pkg::*;
#(
    parameter int N = MATH_OPERAND_W
) (
    input  logic [N-1:0]   multiplier,
    input  logic [N-1:0]   multiplicand,
    output logic [2*N-1:0] product
);
    // row inputs, index N is what is left after the last row
    logic [N-1:0] c_row  [0:N];
    logic [N-1:0] p_row  [0:N];
    // raw cell outputs per row
    logic [N-1:0] c_cell [0:N-1];
    logic [N-1:0] p_cell [0:N-1];

    logic [N-1:0] low_bits;   // product[N-1:0], one per row
    logic [N-1:0] high_bits;  // result of the final ripple add

    // nothing enters the top row
    assign c_row[0] = '0;
    assign p_row[0] = '0;

    for (genvar i = 0; i < N; i++) begin : gen_row
        for (genvar j = 0; j < N; j++) begin : gen_col
            math_multiplier_basic_cell u_cell (
                .i_bit (multiplier[i]),
                .j_bit (multiplicand[j]),
                .c_in  (c_row[i][j]),
                .p_in  (p_row[i][j]),
                .c_out (c_cell[i][j]),
                .p_out (p_cell[i][j])
            );
        end

        // carries keep their column, weight i+j+1 lands on row i+1 column j
        assign c_row[i+1] = c_cell[i];

        // sums move one column right, top column gets a zero
        // column 0 sum leaves the array as a finished product bit
        assign p_row[i+1] = {1'b0, p_cell[i][N-1:1]};
    end

    always_comb begin
        for (int k = 0; k < N; k++) begin
            low_bits[k] = p_cell[k][0];
        end
    end

    // merge the remaining sum and carry vectors, weight N upwards
    // unsigned N x N fits in 2N bits so the carry out is always zero
    assign high_bits = p_row[N] + c_row[N];

    assign product = {high_bits, low_bits};

endmodule : math_multiplier_carry_save

//--- rtl/math_multiplier_basic_cell.sv
`timescale 1ns/10ps

module math_multiplier_basic_cell (
    input  logic i_bit,  // multiplier bit of this row
    input  logic j_bit,  // multiplicand bit of this column
    input  logic c_in,   // carry from the cell above
    input  logic p_in,   // sum from the row above
    output logic c_out,
    output logic p_out
);
    logic pp;

    // partial product bit, weight i+j
    assign pp = i_bit & j_bit;

    // full adder of pp, p_in and c_in
    assign p_out = pp ^ p_in ^ c_in;
    assign c_out = (pp & p_in) | (pp & c_in) | (p_in & c_in);

endmodule : math_multiplier_basic_cell

//--- rtl/math_op_pkg.sv
package math_op_pkg;

    // accumulate operation issued with each multiply
    // it travels down the pipeline next to the operands and
    // is applied once the product is available
    typedef enum logic [1:0] {
        OP_LOAD = 2'b00,  // acc takes the product
        OP_ADD  = 2'b01,  // acc plus product
        OP_SUB  = 2'b10   // acc minus product
    } mac_op_e;

    // 2'b11 is not assigned, and the accumulator
    // treats it the same as OP_LOAD

endpackage : math_op_pkg

//--- rtl/math_cfg_pkg.sv
package math_cfg_pkg;

    // operand width of the MAC datapath
    // the top level passes it down as N, so the array and the stage follow it
    localparam int MATH_OPERAND_W = 8;

    // accumulator width, kept at 2*MATH_OPERAND_W or wider
    // the extra bits give headroom before the running sum wraps
    localparam int MATH_ACC_W = 24;

endpackage : math_cfg_pkg
